//--- Makefile
VERILATOR ?= verilator
TOP       ?= dmaTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP) with Verilator"
	@echo "  clean  remove $(BUILD_DIR)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/dma.sv
`timescale 1ns/1ns

module dma import dmaPkg::*; (
	input  logic                   dif,
	input  logic                   rstN,
	input  logic                   csN,
	input  logic                   regWr,
	input  logic                   regRd,
	input  regAddrT                regAddr,
	input  dataT                   dbIn,
	output dataT                   dbOut,
	input  logic [NumChannels-1:0] dreq,
	output logic [NumChannels-1:0] dack,
	output logic                   hrq,
	input  logic                   hlda,
	output logic                   aen,
	output logic                   adstb,
	output addrT                   addrOut,
	output logic                   iorN,
	output logic                   iowN,
	output logic                   memrN,
	output logic                   memwN,
	input  logic                   eopN,
	output logic                   eopOutN
);

	logic                   reqValid;
	logic                   grantLoad;
	logic                   xferDone;
	chanT                   activeCh;
	logic [1:0]             xferType;
	logic                   extWrite;
	logic [NumChannels-1:0] chMask;
	logic                   rotate;
	logic                   ctrlDisable;
	logic                   autoInit;
	logic                   addrDec;
	logic                   ldTemp;
	logic                   wrBack;
	logic                   tcNext;
	logic                   tcEvent;
	dataT                   rdData;   // Datapath readback

	dmaRegisters regs (
		.dif, .rstN, .csN, .regWr, .regRd, .regAddr, .dbIn, .dbOut, .rdData,
		.activeCh, .tcEvent, .chMask, .rotate, .ctrlDisable, .extWrite,
		.xferType, .autoInit, .addrDec
	);

	dmaPriority prio (
		.dif, .rstN, .dreq, .chMask, .rotate, .ctrlDisable, .grantLoad,
		.xferDone, .reqValid, .activeCh
	);

	dmaDatapath dp (
		.dif, .rstN, .csN, .regWr, .regAddr, .dbIn, .rdData, .activeCh,
		.ldTemp, .wrBack, .autoInit, .addrDec, .addrOut, .tcNext
	);

	dmaTimingControl timing (
		.dif, .rstN, .reqValid, .hlda, .eopN, .xferType, .extWrite, .tcNext,
		.grantLoad, .xferDone, .ldTemp, .wrBack, .tcEvent, .activeCh, .hrq,
		.aen, .adstb, .dack, .iorN, .iowN, .memrN, .memwN, .eopOutN
	);

endmodule

//--- hdl/dmaDatapath.sv
`timescale 1ns/1ns

module dmaDatapath import dmaPkg::*; (
	input  logic    dif,
	input  logic    rstN,
	input  logic    csN,
	input  logic    regWr,
	input  regAddrT regAddr,
	input  dataT    dbIn,
	output dataT    rdData,
	input  chanT    activeCh,
	input  logic    ldTemp,
	input  logic    wrBack,
	input  logic    autoInit,
	input  logic    addrDec,
	output addrT    addrOut,
	output logic    tcNext
);

	addrT  baseAddr  [NumChannels];
	addrT  curAddr   [NumChannels];
	countT baseCount [NumChannels];
	countT curCount  [NumChannels];
	addrT  tempAddr;
	countT tempCount;
	addrT  stepAddr;
	countT stepCount;
	logic  addrSel;
	logic  countSel;

	assign addrSel  = regAddr[3:2] == RegAddrBase[3:2];
	assign countSel = regAddr[3:2] == RegCountBase[3:2];

	assign stepAddr  = addrDec ? tempAddr - 1'b1 : tempAddr + 1'b1;
	assign stepCount = tempCount - 1'b1;
	assign tcNext    = tempCount == '0; // Last word of the block

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NumChannels; i++) begin
				baseAddr[i]  <= '0;
				curAddr[i]   <= '0;
				baseCount[i] <= '0;
				curCount[i]  <= '0;
			end
		end else if (wrBack) begin
			if (tcNext && autoInit) begin
				curAddr[activeCh]  <= baseAddr[activeCh];
				curCount[activeCh] <= baseCount[activeCh];
			end else begin
				curAddr[activeCh]  <= stepAddr;
				curCount[activeCh] <= stepCount;
			end
		end else if (!csN && regWr) begin
			// Programming sets base and current together
			if (addrSel) begin
				baseAddr[regAddr[1:0]] <= dbIn;
				curAddr[regAddr[1:0]]  <= dbIn;
			end else if (countSel) begin
				baseCount[regAddr[1:0]] <= dbIn;
				curCount[regAddr[1:0]]  <= dbIn;
			end
		end
	end

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			tempAddr  <= '0;
			tempCount <= '0;
		end else if (ldTemp) begin
			tempAddr  <= curAddr[activeCh];
			tempCount <= curCount[activeCh];
		end
	end

	// Current address is on the bus already in S1
	assign addrOut = ldTemp ? curAddr[activeCh] : tempAddr;

	// Current address and count readback
	always_comb begin
		if (addrSel) begin
			rdData = curAddr[regAddr[1:0]];
		end else if (countSel) begin
			rdData = curCount[regAddr[1:0]];
		end else begin
			rdData = '0;
		end
	end

endmodule

//--- hdl/dmaPkg.sv
package dmaPkg;

	localparam int NumChannels = 4;

	// Bus and register widths
	typedef logic [15:0] addrT;    // Memory address
	typedef logic [15:0] countT;   // Words to move, minus one
	typedef logic [15:0] dataT;    // CPU data bus
	typedef logic [1:0]  chanT;    // Channel number
	typedef logic [3:0]  regAddrT; // Register select

	// CPU register map
	localparam regAddrT RegAddrBase      = 4'd0;  // Channels 0-3 address
	localparam regAddrT RegCountBase     = 4'd4;  // Channels 0-3 count
	localparam regAddrT RegCommandStatus = 4'd8;  // Write command, read status
	localparam regAddrT RegMaskSingle    = 4'd10;
	localparam regAddrT RegMode          = 4'd11;
	localparam regAddrT RegMasterClear   = 4'd13;
	localparam regAddrT RegMaskAll       = 4'd15;

	// Command register bits
	localparam int CmdDisable  = 2;
	localparam int CmdRotate   = 4;
	localparam int CmdExtWrite = 5;

	// Mode register fields
	localparam int ModeXferHi    = 3;
	localparam int ModeXferLo    = 2;
	localparam int ModeAutoInit  = 4;
	localparam int ModeDecrement = 5;

	localparam logic [1:0] XferVerify = 2'b00;
	localparam logic [1:0] XferWrite  = 2'b01; // I/O to memory
	localparam logic [1:0] XferRead   = 2'b10; // Memory to I/O

	// Bus cycle states
	typedef enum logic [2:0] {
		stIdle,
		stS0,
		stS1,
		stS2,
		stS3,
		stS4
	} dmaStateT;

endpackage

//--- hdl/dmaPriority.sv
`timescale 1ns/1ns

module dmaPriority import dmaPkg::*; (
	input  logic                   dif,
	input  logic                   rstN,
	input  logic [NumChannels-1:0] dreq,
	input  logic [NumChannels-1:0] chMask,
	input  logic                   rotate,
	input  logic                   ctrlDisable,
	input  logic                   grantLoad,
	input  logic                   xferDone,
	output logic                   reqValid,
	output chanT                   activeCh
);

	logic [NumChannels-1:0] dreqSync;
	logic [NumChannels-1:0] pending;
	chanT                   prioPtr;  // Highest priority channel
	chanT                   winner;
	chanT                   idx;
	logic                   found;

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			dreqSync <= '0;
		end else begin
			dreqSync <= dreq;
		end
	end

	assign pending  = dreqSync & ~chMask & {NumChannels{!ctrlDisable}};
	assign reqValid = |pending;

	// Search from the pointer upward, wrapping around
	always_comb begin
		winner = prioPtr;
		found  = 1'b0;
		idx    = prioPtr;
		for (int i = 0; i < NumChannels; i++) begin
			idx = prioPtr + chanT'(i);
			if (!found && pending[idx]) begin
				winner = idx;
				found  = 1'b1;
			end
		end
	end

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			prioPtr <= '0;
		end else if (!rotate) begin
			prioPtr <= '0; // Fixed, channel 0 first
		end else if (xferDone) begin
			prioPtr <= activeCh + 1'b1; // Served channel goes last
		end
	end

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			activeCh <= '0;
		end else if (grantLoad) begin
			activeCh <= winner;
		end
	end

endmodule

//--- hdl/dmaRegisters.sv
`timescale 1ns/1ns

module dmaRegisters import dmaPkg::*; (
	input  logic                   dif,
	input  logic                   rstN,
	input  logic                   csN,
	input  logic                   regWr,
	input  logic                   regRd,
	input  regAddrT                regAddr,
	input  dataT                   dbIn,
	output dataT                   dbOut,
	input  dataT                   rdData,
	input  chanT                   activeCh,
	input  logic                   tcEvent,
	output logic [NumChannels-1:0] chMask,
	output logic                   rotate,
	output logic                   ctrlDisable,
	output logic                   extWrite,
	output logic [1:0]             xferType,
	output logic                   autoInit,
	output logic                   addrDec
);

	logic [7:0]             commandReg;
	logic [7:0]             modeReg [NumChannels];
	logic [NumChannels-1:0] tcStatus;  // Terminal count flags per channel
	logic                   wrEn;
	logic                   statusRd;

	assign wrEn     = !csN && regWr;
	assign statusRd = !csN && regRd && (regAddr == RegCommandStatus);

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			commandReg <= '0;
			chMask     <= '1;
			tcStatus   <= '0;
			for (int i = 0; i < NumChannels; i++) begin
				modeReg[i] <= '0;
			end
		end else begin
			if (statusRd) begin
				tcStatus <= '0; // Cleared by reading
			end
			if (wrEn) begin
				case (regAddr)
					RegCommandStatus: commandReg <= dbIn[7:0];
					RegMode:          modeReg[dbIn[1:0]] <= dbIn[7:0];
					RegMaskSingle:    chMask[dbIn[1:0]] <= dbIn[2];
					RegMaskAll:       chMask <= dbIn[NumChannels-1:0];
					RegMasterClear: begin
						commandReg <= '0;
						chMask     <= '1;
						tcStatus   <= '0;
						for (int i = 0; i < NumChannels; i++) begin
							modeReg[i] <= '0;
						end
					end
					default: ;
				endcase
			end
			// Terminal count or external abort on the channel in service
			if (tcEvent) begin
				tcStatus[activeCh] <= 1'b1;
				if (!modeReg[activeCh][ModeAutoInit]) begin
					chMask[activeCh] <= 1'b1;
				end
			end
		end
	end

	// Command decode
	assign ctrlDisable = commandReg[CmdDisable];
	assign rotate      = commandReg[CmdRotate];
	assign extWrite    = commandReg[CmdExtWrite];

	// Mode of the channel in service
	assign xferType = modeReg[activeCh][ModeXferHi:ModeXferLo];
	assign autoInit = modeReg[activeCh][ModeAutoInit];
	assign addrDec  = modeReg[activeCh][ModeDecrement];

	// Status here, everything else from the datapath
	always_comb begin
		if (statusRd) begin
			dbOut = {{($bits(dataT) - NumChannels){1'b0}}, tcStatus};
		end else begin
			dbOut = rdData;
		end
	end

endmodule

//--- hdl/dmaTimingControl.sv
`timescale 1ns/1ns

module dmaTimingControl import dmaPkg::*; (
	input  logic                   dif,
	input  logic                   rstN,
	input  logic                   reqValid,
	input  logic                   hlda,
	input  logic                   eopN,
	input  logic [1:0]             xferType,
	input  logic                   extWrite,
	input  logic                   tcNext,
	output logic                   grantLoad,
	output logic                   xferDone,
	output logic                   ldTemp,
	output logic                   wrBack,
	output logic                   tcEvent,
	input  chanT                   activeCh,
	output logic                   hrq,
	output logic                   aen,
	output logic                   adstb,
	output logic [NumChannels-1:0] dack,
	output logic                   iorN,
	output logic                   iowN,
	output logic                   memrN,
	output logic                   memwN,
	output logic                   eopOutN
);

	dmaStateT state;
	dmaStateT nextState;
	logic     inXfer;   // S1 through S3
	logic     strobe;   // S2 or S3
	logic     abort;

	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	assign inXfer = (state == stS1) || (state == stS2) || (state == stS3);
	assign strobe = (state == stS2) || (state == stS3);
	assign abort  = inXfer && !eopN;

	always_comb begin
		nextState = state;
		case (state)
			stIdle: if (reqValid) nextState = stS0;
			stS0:   if (hlda) nextState = stS1; // Waits on the bus master
			stS1:   nextState = eopN ? stS2 : stIdle;
			stS2: begin
				if (!eopN) begin
					nextState = stIdle;
				end else if (extWrite) begin
					nextState = stS3;
				end else begin
					nextState = stS4;
				end
			end
			stS3:   nextState = eopN ? stS4 : stIdle;
			stS4:   nextState = stIdle;
			default: nextState = stIdle;
		endcase
	end

	// Handshake with priority and datapath
	assign grantLoad = (state == stIdle) && reqValid;
	assign xferDone  = state == stS4;
	assign ldTemp    = state == stS1;
	assign wrBack    = state == stS4;
	assign tcEvent   = (wrBack && tcNext) || abort;

	// Bus control decoded from state
	assign hrq   = (state == stS0) || inXfer;
	assign aen   = inXfer;
	assign adstb = state == stS1;

	always_comb begin
		iorN  = 1'b1;
		iowN  = 1'b1;
		memrN = 1'b1;
		memwN = 1'b1;
		if (strobe) begin
			case (xferType)
				XferWrite: begin
					iorN  = 1'b0;
					memwN = 1'b0;
				end
				XferRead: begin
					memrN = 1'b0;
					iowN  = 1'b0;
				end
				XferVerify: ; // Address cycle only
				default: ;
			endcase
		end
	end

	// Registered outputs, set up from the next state
	always_ff @(posedge dif or negedge rstN) begin
		if (!rstN) begin
			dack    <= '0;
			eopOutN <= 1'b1;
		end else begin
			if ((nextState == stS1) || (nextState == stS2) || (nextState == stS3)) begin
				dack <= NumChannels'(1) << activeCh;
			end else begin
				dack <= '0;
			end
			eopOutN <= !((nextState == stS4) && tcNext);
		end
	end

endmodule

//--- sim.f
hdl/dmaPkg.sv
hdl/dmaRegisters.sv
hdl/dmaPriority.sv
hdl/dmaDatapath.sv
hdl/dmaTimingControl.sv
hdl/dma.sv
testbench/dmaTb.sv

//--- testbench/dmaTb.sv
`timescale 1ns/1ns

module dmaTb import dmaPkg::*; ();

	localparam int ClkPeriod     = 8;
	localparam int NumRows       = 9;
	localparam int TimeoutCycles = NumRows * 200;

	typedef struct packed {
		chanT        ch;       // Channel read back at the end
		addrT        base;
		countT       count;
		logic [7:0]  mode;
		logic [7:0]  command;
		logic [3:0]  reqSet;
		logic [31:0] order;    // Served channels as nibbles from the left
		logic [3:0]  nOrder;
		logic [3:0]  abortAt;  // Transfer cut short by eopN or 0 for none
		addrT        expAddr;
		countT       expCount;
		logic [3:0]  expTc;
	} rowT;

	logic                   dif = 1'b0;
	logic                   rstN;
	logic                   csN;
	logic                   regWr;
	logic                   regRd;
	logic                   hlda;
	logic                   eopN;
	logic                   hrq;
	logic                   aen;
	logic                   adstb;
	logic                   iorN;
	logic                   iowN;
	logic                   memrN;
	logic                   memwN;
	logic                   eopOutN;
	regAddrT                regAddr;
	dataT                   dbIn;
	dataT                   dbOut;
	addrT                   addrOut;
	logic [NumChannels-1:0] dreq;
	logic [NumChannels-1:0] dack;

	rowT    rows [NumRows];
	rowT    cur;           // Row in progress
	logic   clearStats;
	integer seed = 69977;
	int     hrqCycles;
	int     eopCount;
	int     aenCycles;
	int     xferIdx [NumChannels];
	int     servedQ [$];

	dma uut (.*);

	always #(ClkPeriod / 2) dif = !dif;

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic writeReg(input regAddrT addr, input dataT data);
		@(posedge dif);
		csN     <= 1'b0;
		regWr   <= 1'b1;
		regAddr <= addr;
		dbIn    <= data;
		@(posedge dif);
		csN   <= 1'b1;
		regWr <= 1'b0;
	endtask

	task automatic readReg(input regAddrT addr, output dataT data);
		@(posedge dif);
		csN     <= 1'b0;
		regRd   <= 1'b1;
		regAddr <= addr;
		@(negedge dif);
		data = dbOut;
		@(posedge dif); // Status read clears TC here
		csN   <= 1'b1;
		regRd <= 1'b0;
	endtask

	task automatic clearCounters();
		@(posedge dif);
		clearStats <= 1'b1;
		@(posedge dif);
		clearStats <= 1'b0;
	endtask

	// Order is iorN, iowN, memrN, memwN
	function automatic logic [3:0] busStrobes(input logic [7:0] mode);
		case (mode[ModeXferHi:ModeXferLo])
			XferWrite: return 4'b0110;
			XferRead:  return 4'b1001;
			default:   return 4'b1111;
		endcase
	endfunction

	// Bus master granting after 0 to 5 idle cycles
	initial begin
		int delayCycles;
		hlda <= 1'b0;
		forever begin
			@(negedge dif);
			if (hrq && !hlda) begin
				delayCycles = $unsigned($random(seed)) % 6;
				repeat (delayCycles) @(posedge dif);
				@(posedge dif);
				hlda <= 1'b1;
			end else if (!hrq && hlda) begin
				@(posedge dif);
				hlda <= 1'b0;
			end
		end
	end

	// Bus monitor
	always @(negedge dif) begin
		int   ch;
		int   offset;
		addrT expAddr;
		if (clearStats) begin
			hrqCycles = 0;
			eopCount  = 0;
			aenCycles = 0;
			servedQ.delete();
			for (int i = 0; i < NumChannels; i++) begin
				xferIdx[i] = 0;
			end
		end else if (rstN) begin
			if (hrq) hrqCycles++;
			if (!eopOutN) eopCount++;
			// S2 and S3 are the aen cycles without adstb
			check("strobes", 32'({iorN, iowN, memrN, memwN}),
				32'((aen && !adstb) ? busStrobes(cur.mode) : 4'b1111));
			if (adstb) begin
				ch = 0;
				for (int i = 0; i < NumChannels; i++) begin
					if (dack[i]) ch = i;
				end
				check("dack", 32'(dack), 32'(4'b0001 << ch));
				offset  = xferIdx[ch] % (int'(cur.count) + 1); // Auto-init wraps to base
				expAddr = cur.mode[ModeDecrement] ? cur.base - addrT'(offset)
					: cur.base + addrT'(offset);
				check("addrOut", 32'(addrOut), 32'(expAddr));
				xferIdx[ch]++;
				servedQ.push_back(ch);
			end
			if (aen) begin
				// Same channel acknowledged from S1 to the last strobe
				check("dack during transfer", 32'(dack), 32'(4'b0001 << ch));
				aenCycles++;
			end else begin
				check("dack outside transfer", 32'(dack), 32'd0);
				if (aenCycles != 0) begin
					// S1 and S2 plus S3 with extended write
					check("aen cycles", 32'(aenCycles),
						cur.command[CmdExtWrite] ? 32'd3 : 32'd2);
					aenCycles = 0;
				end
			end
		end
	end

	initial begin
		#(TimeoutCycles * ClkPeriod);
		$display("Timeout: the DMA did not finish within %0d cycles", TimeoutCycles);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		dataT rdVal;
		rstN       <= 1'b0;
		csN        <= 1'b1;
		regWr      <= 1'b0;
		regRd      <= 1'b0;
		regAddr    <= '0;
		dbIn       <= '0;
		dreq       <= '0;
		eopN       <= 1'b1;
		clearStats <= 1'b0;
		cur = '0;
		// ch, base, count, mode, command, reqSet, order, nOrder, abortAt, addr, count, tc
		rows[0] = '{2'd2, 16'h1000, 16'd3, 8'h04, 8'h00, 4'b0100, 32'h2222_0000, 4'd4, 4'd0,
			16'h1004, 16'hFFFF, 4'b0100}; // Write
		rows[1] = '{2'd0, 16'h3000, 16'd2, 8'h08, 8'h00, 4'b0001, 32'h0000_0000, 4'd3, 4'd0,
			16'h3003, 16'hFFFF, 4'b0001}; // Read
		rows[2] = '{2'd3, 16'h0100, 16'd0, 8'h00, 8'h00, 4'b1000, 32'h3000_0000, 4'd1, 4'd0,
			16'h0101, 16'hFFFF, 4'b1000}; // Verify
		rows[3] = '{2'd1, 16'h1005, 16'd3, 8'h24, 8'h00, 4'b0010, 32'h1111_0000, 4'd4, 4'd0,
			16'h1001, 16'hFFFF, 4'b0010}; // Decrement
		rows[4] = '{2'd0, 16'h2000, 16'd1, 8'h04, 8'h20, 4'b0001, 32'h0000_0000, 4'd2, 4'd0,
			16'h2002, 16'hFFFF, 4'b0001}; // Extended write
		rows[5] = '{2'd2, 16'h5000, 16'd2, 8'h14, 8'h00, 4'b0100, 32'h2220_0000, 4'd3, 4'd0,
			16'h5000, 16'd2, 4'b0100};    // Auto-init
		rows[6] = '{2'd2, 16'h6000, 16'd1, 8'h04, 8'h00, 4'b0101, 32'h0022_0000, 4'd4, 4'd0,
			16'h6002, 16'hFFFF, 4'b0101}; // Fixed priority
		rows[7] = '{2'd3, 16'h6000, 16'd1, 8'h04, 8'h10, 4'b1110, 32'h1231_2300, 4'd6, 4'd0,
			16'h6002, 16'hFFFF, 4'b1110}; // Rotating priority
		rows[8] = '{2'd3, 16'h4000, 16'd4, 8'h04, 8'h00, 4'b1000, 32'h3330_0000, 4'd3, 4'd3,
			16'h4002, 16'd2, 4'b1000};    // External abort
		repeat (4) @(posedge dif);
		rstN <= 1'b1;
		clearCounters();
		@(negedge dif);
		check("outputs after reset", 32'({hrq, aen, adstb, dack, iorN, iowN, memrN, memwN,
			eopOutN}), 32'(12'h01F));
		readReg(RegCommandStatus, rdVal);
		check("status after reset", 32'(rdVal), 32'd0);
		dreq <= '1; // All masks still set
		repeat (20) @(posedge dif);
		dreq <= '0;
		check("hrq cycles while masked", 32'(hrqCycles), 32'd0);
		for (int r = 0; r < NumRows; r++) begin
			cur = rows[r];
			writeReg(RegMasterClear, '0);
			writeReg(RegCommandStatus, dataT'(cur.command));
			for (int c = 0; c < NumChannels; c++) begin
				if (cur.reqSet[c]) begin
					writeReg(regAddrT'(RegAddrBase + c), cur.base);
					writeReg(regAddrT'(RegCountBase + c), cur.count);
					writeReg(RegMode, dataT'({cur.mode[7:2], 2'(c)}));
					writeReg(RegMaskSingle, dataT'(c)); // Bit 2 low unmasks
				end
			end
			clearCounters();
			dreq <= cur.reqSet;
			if (cur.abortAt != 0) begin
				while (servedQ.size() < int'(cur.abortAt)) @(posedge dif);
				eopN <= 1'b0; // Seen during S2
				@(posedge dif);
				eopN <= 1'b1;
			end
			while (servedQ.size() < int'(cur.nOrder)) @(posedge dif);
			dreq <= '0;
			repeat (16) @(posedge dif);
			check("transfers", 32'(servedQ.size()), 32'(cur.nOrder));
			for (int i = 0; i < int'(cur.nOrder); i++) begin
				check("served channel", 32'(servedQ[i]), 32'(cur.order[31 - 4 * i -: 4]));
			end
			// One eopOutN pulse per finished block
			check("eopOutN low cycles", 32'(eopCount),
				(cur.abortAt != 0) ? 32'd0 : 32'(int'(cur.nOrder) / (int'(cur.count) + 1)));
			readReg(regAddrT'(RegAddrBase + cur.ch), rdVal);
			check("current address", 32'(rdVal), 32'(cur.expAddr));
			readReg(regAddrT'(RegCountBase + cur.ch), rdVal);
			check("current count", 32'(rdVal), 32'(cur.expCount));
			readReg(RegCommandStatus, rdVal);
			check("TC status", 32'(rdVal), 32'(cur.expTc));
			// Only an auto-init channel stays unmasked after TC
			clearCounters();
			dreq <= cur.reqSet;
			repeat (16) @(posedge dif);
			dreq <= '0;
			repeat (16) @(posedge dif);
			check("served after TC", 32'(hrqCycles != 0), 32'(cur.mode[ModeAutoInit]));
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule
